//--- verilog/sparse_pkg.sv
// ========================================
// sparse_pkg: widths, bank and FSM enums,
// and the value and result types
// ========================================
`default_nettype none

package sparse_pkg;

    localparam int WORD_W  = 16;              // stored nonzero value
    localparam int INDEX_W = 6;               // index inside one bank
    localparam int ADDR_W  = 2 + INDEX_W;     // bank field on top of the index
    localparam int ACC_W   = 2 * WORD_W + 1;  // two full products plus a carry
    localparam int LANES   = 2;               // lanes per bitmap entry
    localparam int MAX_DIM = 8;               // largest row or column count
    localparam int DIM_W   = 4;               // counts and indices

    // bank code is the top two bits of a memory address
    typedef enum logic [1:0] {
        BANK_A0,
        BANK_A1,
        BANK_B0,
        BANK_B1
    } bank_e;

    typedef logic [LANES-1:0]  lane_mask_t;
    typedef logic [WORD_W-1:0] word_t;
    typedef logic [ACC_W-1:0]  acc_t;

    typedef enum logic [1:0] {
        WALK_IDLE,
        WALK_ISSUE,   // walking pairs, one per idle fetch
        WALK_WAIT,    // all pairs issued, results still draining
        WALK_DONE
    } walk_state_e;

    typedef enum logic [1:0] {
        FETCH_IDLE,
        FETCH_READ_A,
        FETCH_READ_B,
        FETCH_CLOSE   // B data lands here and the beat goes out
    } fetch_state_e;

endpackage

`default_nettype wire

//--- verilog/sparse_ifs.sv
// ========================================
// pair, memory and operand interfaces of
// the sparse dot-product engine
// ========================================
`timescale 1ns/100ps
`default_nettype none

interface pair_if;
    import sparse_pkg::*;

    logic               issue;     // one-cycle strobe per pair
    lane_mask_t         mask;      // A lanes AND B lanes of this pair
    logic [INDEX_W-1:0] a_index0;
    logic [INDEX_W-1:0] a_index1;
    logic [INDEX_W-1:0] b_index0;
    logic [INDEX_W-1:0] b_index1;
    logic [DIM_W-1:0]   row;
    logic [DIM_W-1:0]   col;

    modport source (output issue, mask, a_index0, a_index1, b_index0, b_index1, row, col);
    modport sink   (input  issue, mask, a_index0, a_index1, b_index0, b_index1, row, col);
endinterface

interface ram_if;
    import sparse_pkg::*;

    logic              req;     // held with addr until gnt
    logic [ADDR_W-1:0] addr;
    logic              gnt;
    word_t             rdata;
    logic              rvalid;  // one cycle after gnt

    modport requester (output req, addr, input gnt, rdata, rvalid);
    modport responder (input req, addr, output gnt, rdata, rvalid);
endinterface

interface operand_if;
    import sparse_pkg::*;

    logic             beat;
    logic             used;   // low only on the single beat of an empty pair
    word_t            a_val;
    word_t            b_val;
    logic             last;
    logic [DIM_W-1:0] row;
    logic [DIM_W-1:0] col;

    modport source (output beat, used, a_val, b_val, last, row, col);
    modport sink   (input  beat, used, a_val, b_val, last, row, col);
endinterface

`default_nettype wire

//--- verilog/pair_walker.sv
// ========================================
// pair_walker: steps the row and column
// pairs and keeps the nonzero pointers
// ========================================
`timescale 1ns/100ps
`default_nettype none

module pair_walker #(
    parameter int MAX_ROWS = sparse_pkg::MAX_DIM,
    parameter int MAX_COLS = sparse_pkg::MAX_DIM
) (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic                                  start,
    input  logic [sparse_pkg::DIM_W-1:0]          num_rows,
    input  logic [sparse_pkg::DIM_W-1:0]          num_cols,
    input  logic [sparse_pkg::LANES*MAX_ROWS-1:0] bitmap_a,
    input  logic [sparse_pkg::LANES*MAX_COLS-1:0] bitmap_b,
    input  logic                                  fetch_busy,
    input  logic                                  pair_done,
    output logic                                  walk_busy,
    output logic                                  done,
    pair_if.source                                pair
);
    import sparse_pkg::*;

    localparam int CNT_W = 2 * DIM_W;

    walk_state_e        state;
    logic [DIM_W-1:0]   rows_r;
    logic [DIM_W-1:0]   cols_r;
    logic [DIM_W-1:0]   row;
    logic [DIM_W-1:0]   col;
    logic [CNT_W-1:0]   total;
    logic [CNT_W-1:0]   res_cnt;   // results seen in this run
    logic [INDEX_W-1:0] a_ptr [LANES];
    logic [INDEX_W-1:0] b_ptr [LANES];
    lane_mask_t         a_bits;
    lane_mask_t         b_bits;
    logic               last_col;
    logic               last_row;

    assign a_bits   = bitmap_a[row*LANES +: LANES];  // lane l of row r sits at bit r*2+l
    assign b_bits   = bitmap_b[col*LANES +: LANES];
    assign last_col = (col == cols_r - 1'b1);
    assign last_row = (row == rows_r - 1'b1);

    assign pair.issue    = (state == WALK_ISSUE) && !fetch_busy;
    assign pair.mask     = a_bits & b_bits;
    assign pair.a_index0 = a_ptr[0];
    assign pair.a_index1 = a_ptr[1];
    assign pair.b_index0 = b_ptr[0];
    assign pair.b_index1 = b_ptr[1];
    assign pair.row      = row;
    assign pair.col      = col;

    assign walk_busy = (state != WALK_IDLE);
    assign done      = (state == WALK_DONE);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state   <= WALK_IDLE;
            rows_r  <= '0;
            cols_r  <= '0;
            row     <= '0;
            col     <= '0;
            total   <= '0;
            res_cnt <= '0;
            for (int l = 0; l < LANES; l++) begin
                a_ptr[l] <= '0;
                b_ptr[l] <= '0;
            end
        end else begin
            if (pair_done) begin
                res_cnt <= res_cnt + 1'b1;
            end
            case (state)
                WALK_IDLE: begin
                    if (start) begin
                        rows_r  <= num_rows;
                        cols_r  <= num_cols;
                        total   <= num_rows * num_cols;
                        res_cnt <= '0;
                        row     <= '0;
                        col     <= '0;
                        for (int l = 0; l < LANES; l++) begin
                            a_ptr[l] <= '0;
                            b_ptr[l] <= '0;
                        end
                        // an empty matrix has nothing to walk
                        state <= (num_rows == '0 || num_cols == '0) ? WALK_DONE : WALK_ISSUE;
                    end
                end
                WALK_ISSUE: begin
                    if (pair.issue) begin
                        if (last_col) begin
                            col <= '0;
                            row <= row + 1'b1;
                            for (int l = 0; l < LANES; l++) begin
                                a_ptr[l] <= a_ptr[l] + a_bits[l];  // row used a value in lane l
                                b_ptr[l] <= '0;                    // B restarts on every row
                            end
                            if (last_row) begin
                                state <= WALK_WAIT;
                            end
                        end else begin
                            col <= col + 1'b1;
                            for (int l = 0; l < LANES; l++) begin
                                b_ptr[l] <= b_ptr[l] + b_bits[l];
                            end
                        end
                    end
                end
                WALK_WAIT: begin
                    if (pair_done && res_cnt == total - 1'b1) begin
                        state <= WALK_DONE;
                    end
                end
                default: state <= WALK_IDLE;  // done lasts one cycle
            endcase
        end
    end

    // the host waits for done before starting again
    a_start_idle: assert property (@(posedge clk) disable iff (!rst) start |-> !walk_busy);

endmodule

`default_nettype wire

//--- verilog/operand_fetch.sv
// ========================================
// operand_fetch: reads A and B values for
// each set lane and sends operand beats
// ========================================
`timescale 1ns/100ps
`default_nettype none

module operand_fetch (
    input  logic      clk,
    input  logic      rst,
    output logic      fetch_busy,
    pair_if.sink      pair,
    ram_if.requester  ram,
    operand_if.source op
);
    import sparse_pkg::*;

    fetch_state_e       state;
    lane_mask_t         lanes;   // lanes of this pair still to fetch
    lane_mask_t         rest;
    logic               lane;    // lane being fetched
    logic [INDEX_W-1:0] a_idx [LANES];
    logic [INDEX_W-1:0] b_idx [LANES];
    logic [DIM_W-1:0]   row_r;
    logic [DIM_W-1:0]   col_r;
    word_t              a_hold;
    bank_e              bank;
    logic [INDEX_W-1:0] idx;
    logic               take;
    logic               close_beat;

    assign fetch_busy = (state != FETCH_IDLE);
    assign take       = (state == FETCH_IDLE) && pair.issue;
    // an empty pair closes at once with no read behind it
    assign close_beat = (state == FETCH_CLOSE) && (lanes == '0 || ram.rvalid);

    always_comb begin
        rest       = lanes;
        rest[lane] = 1'b0;
    end

    always_comb begin
        if (state == FETCH_READ_B) begin
            bank = lane ? BANK_B1 : BANK_B0;
            idx  = b_idx[lane];
        end else begin
            bank = lane ? BANK_A1 : BANK_A0;
            idx  = a_idx[lane];
        end
    end

    assign ram.req  = (state == FETCH_READ_A) || (state == FETCH_READ_B);
    assign ram.addr = {bank, idx};

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state   <= FETCH_IDLE;
            lanes   <= '0;
            lane    <= 1'b0;
            op.beat <= 1'b0;
        end else begin
            op.beat <= close_beat;
            case (state)
                FETCH_IDLE: begin
                    if (take) begin
                        lanes <= pair.mask;
                        lane  <= ~pair.mask[0];  // lowest set lane goes first
                        state <= (pair.mask == '0) ? FETCH_CLOSE : FETCH_READ_A;
                    end
                end
                FETCH_READ_A: begin
                    if (ram.gnt) begin
                        state <= FETCH_READ_B;
                    end
                end
                FETCH_READ_B: begin
                    if (ram.gnt) begin
                        state <= FETCH_CLOSE;
                    end
                end
                default: begin
                    if (close_beat) begin
                        lanes <= rest;
                        lane  <= ~rest[0];
                        state <= (rest == '0) ? FETCH_IDLE : FETCH_READ_A;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            a_idx[0] <= pair.a_index0;
            a_idx[1] <= pair.a_index1;
            b_idx[0] <= pair.b_index0;
            b_idx[1] <= pair.b_index1;
            row_r    <= pair.row;
            col_r    <= pair.col;
        end
        if (state == FETCH_READ_B && ram.rvalid) begin
            a_hold <= ram.rdata;  // A data returns while B is requested
        end
        if (close_beat) begin
            op.used  <= (lanes != '0);
            op.a_val <= a_hold;
            op.b_val <= ram.rdata;
            op.last  <= (rest == '0);
            op.row   <= row_r;
            op.col   <= col_r;
        end
    end

    // read data only ever answers a granted request of the cycle before
    a_rvalid_granted: assert property (@(posedge clk) disable iff (!rst)
        ram.rvalid |-> $past(ram.req && ram.gnt));

endmodule

`default_nettype wire

//--- verilog/value_store.sv
// ========================================
// value_store: four-bank nonzero memory,
// host writes win over fetch reads
// ========================================
`timescale 1ns/100ps
`default_nettype none

module value_store (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           load_en,
    input  sparse_pkg::bank_e              load_bank,
    input  logic [sparse_pkg::INDEX_W-1:0] load_index,
    input  sparse_pkg::word_t              load_data,
    ram_if.responder                       ram
);
    import sparse_pkg::*;

    localparam int DEPTH = 1 << ADDR_W;  // four banks of 64 words

    word_t mem [DEPTH];

    // the fetcher only gets the cycles that the host leaves free
    assign ram.gnt = ram.req && !load_en;

    // the single port takes one write or one read per cycle
    always_ff @(posedge clk) begin
        if (load_en) begin
            mem[{load_bank, load_index}] <= load_data;
        end else if (ram.gnt) begin
            ram.rdata <= mem[ram.addr];
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            ram.rvalid <= 1'b0;
        end else begin
            ram.rvalid <= ram.gnt;
        end
    end

    // a read held off by a load keeps its request and address until granted
    a_req_held: assert property (@(posedge clk) disable iff (!rst)
        ram.req && !ram.gnt |=> ram.req && $stable(ram.addr));

endmodule

`default_nettype wire

//--- verilog/dot_accumulate.sv
// ========================================
// dot_accumulate: multiplies operand beats
// and emits one sum per pair
// ========================================
`timescale 1ns/100ps
`default_nettype none

module dot_accumulate (
    input  logic                         clk,
    input  logic                         rst,
    output logic                         result_valid,
    output logic [sparse_pkg::DIM_W-1:0] result_row,
    output logic [sparse_pkg::DIM_W-1:0] result_col,
    output sparse_pkg::acc_t             result_value,
    output logic                         pair_done,
    operand_if.sink                      op
);
    import sparse_pkg::*;

    logic [2*WORD_W-1:0] product;
    acc_t                sum;
    acc_t                next_sum;

    assign product  = op.a_val * op.b_val;  // one lane per cycle
    assign next_sum = op.used ? sum + acc_t'(product) : sum;

    assign pair_done = result_valid;  // the walker counts results from this

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            sum          <= '0;
            result_valid <= 1'b0;
        end else begin
            result_valid <= op.beat && op.last;
            if (op.beat) begin
                sum <= op.last ? '0 : next_sum;  // clear for the next pair
            end
        end
    end

    always_ff @(posedge clk) begin
        if (op.beat && op.last) begin
            result_value <= next_sum;
            result_row   <= op.row;
            result_col   <= op.col;
        end
    end

endmodule

`default_nettype wire

//--- verilog/sparse_dot_top.sv
// ========================================
// sparse_dot_top: sparse bitmap matrix by
// vector engine with a host load port
// ========================================
`timescale 1ns/100ps
`default_nettype none

module sparse_dot_top #(
    parameter int MAX_ROWS = sparse_pkg::MAX_DIM,
    parameter int MAX_COLS = sparse_pkg::MAX_DIM
) (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic                                  load_en,
    input  sparse_pkg::bank_e                     load_bank,
    input  logic [sparse_pkg::INDEX_W-1:0]        load_index,
    input  sparse_pkg::word_t                     load_data,
    input  logic                                  start,
    input  logic [sparse_pkg::DIM_W-1:0]          num_rows,
    input  logic [sparse_pkg::DIM_W-1:0]          num_cols,
    input  logic [sparse_pkg::LANES*MAX_ROWS-1:0] bitmap_a,
    input  logic [sparse_pkg::LANES*MAX_COLS-1:0] bitmap_b,
    output logic                                  busy,
    output logic                                  done,
    output logic                                  result_valid,
    output logic [sparse_pkg::DIM_W-1:0]          result_row,
    output logic [sparse_pkg::DIM_W-1:0]          result_col,
    output sparse_pkg::acc_t                      result_value
);
    logic fetch_busy;
    logic pair_done;

    pair_if    pair_bus ();
    ram_if     ram_bus ();
    operand_if op_bus ();

    pair_walker #(
        .MAX_ROWS (MAX_ROWS),
        .MAX_COLS (MAX_COLS)
    ) i_pair_walker (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .num_rows   (num_rows),
        .num_cols   (num_cols),
        .bitmap_a   (bitmap_a),
        .bitmap_b   (bitmap_b),
        .fetch_busy (fetch_busy),
        .pair_done  (pair_done),
        .walk_busy  (busy),
        .done       (done),
        .pair       (pair_bus.source)
    );

    operand_fetch i_operand_fetch (
        .clk        (clk),
        .rst        (rst),
        .fetch_busy (fetch_busy),
        .pair       (pair_bus.sink),
        .ram        (ram_bus.requester),
        .op         (op_bus.source)
    );

    value_store i_value_store (
        .clk        (clk),
        .rst        (rst),
        .load_en    (load_en),
        .load_bank  (load_bank),
        .load_index (load_index),
        .load_data  (load_data),
        .ram        (ram_bus.responder)
    );

    dot_accumulate i_dot_accumulate (
        .clk          (clk),
        .rst          (rst),
        .result_valid (result_valid),
        .result_row   (result_row),
        .result_col   (result_col),
        .result_value (result_value),
        .pair_done    (pair_done),
        .op           (op_bus.sink)
    );

endmodule

`default_nettype wire

//--- dv/tb_clock_gen.sv
// ========================================
// tb_clock_gen: free-running testbench clock
// ========================================
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS = 20
) (
    output logic clk
);
    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk = ~clk;  // half period per edge
        end
    end
endmodule

`default_nettype wire

//--- dv/tb_sparse_dot.sv
// ========================================
// tb_sparse_dot: testbench for the sparse
// bitmap dot-product engine
// ========================================
`timescale 1ns/100ps
`default_nettype none

module tb_sparse_dot;
    import sparse_pkg::*;

    localparam int MAX_ROWS = MAX_DIM;
    localparam int MAX_COLS = MAX_DIM;
    localparam int BM_A_W   = LANES * MAX_ROWS;
    localparam int BM_B_W   = LANES * MAX_COLS;

    logic               clk;
    logic               rst;
    logic               load_en;
    bank_e              load_bank;
    logic [INDEX_W-1:0] load_index;
    word_t              load_data;
    logic               start;
    logic [DIM_W-1:0]   num_rows;
    logic [DIM_W-1:0]   num_cols;
    logic [BM_A_W-1:0]  bitmap_a;
    logic [BM_B_W-1:0]  bitmap_b;
    logic               busy;
    logic               done;
    logic               result_valid;
    logic [DIM_W-1:0]   result_row;
    logic [DIM_W-1:0]   result_col;
    acc_t               result_value;

    word_t              model_mem [4][1 << INDEX_W];  // mirror of the four banks
    acc_t               exp_val [$];
    logic [DIM_W-1:0]   exp_row [$];
    logic [DIM_W-1:0]   exp_col [$];
    string              test_name     = "reset";
    int                 error_count   = 0;
    int                 check_count   = 0;
    int                 result_count  = 0;
    int                 test_count    = 0;
    int                 test_err_base = 0;
    int                 test_res_base = 0;
    int                 wd_limit      = 64;  // covers the reset phase
    int                 wd_count      = 0;

    tb_clock_gen #(.PERIOD_NS(20)) i_clock_gen (.clk(clk));

    sparse_dot_top #(
        .MAX_ROWS (MAX_ROWS),
        .MAX_COLS (MAX_COLS)
    ) i_sparse_dot_top (
        .clk          (clk),
        .rst          (rst),
        .load_en      (load_en),
        .load_bank    (load_bank),
        .load_index   (load_index),
        .load_data    (load_data),
        .start        (start),
        .num_rows     (num_rows),
        .num_cols     (num_cols),
        .bitmap_a     (bitmap_a),
        .bitmap_b     (bitmap_b),
        .busy         (busy),
        .done         (done),
        .result_valid (result_valid),
        .result_row   (result_row),
        .result_col   (result_col),
        .result_value (result_value)
    );

    // lane l of a pair uses the count of earlier rows (columns) holding lane l as its index
    function automatic acc_t expected_dot(input logic [BM_A_W-1:0] bm_a,
                                          input logic [BM_B_W-1:0] bm_b,
                                          input int r, input int c);
        acc_t  sum;
        int    l;
        int    k;
        int    a_idx;
        int    b_idx;
        word_t a_w;
        word_t b_w;
        sum = '0;
        for (l = 0; l < LANES; l++) begin
            a_idx = 0;
            b_idx = 0;
            for (k = 0; k < r; k++) begin
                a_idx += int'(bm_a[k*LANES+l]);
            end
            for (k = 0; k < c; k++) begin
                b_idx += int'(bm_b[k*LANES+l]);
            end
            if (bm_a[r*LANES+l] && bm_b[c*LANES+l]) begin
                a_w = model_mem[int'(BANK_A0) + l][a_idx];
                b_w = model_mem[int'(BANK_B0) + l][b_idx];
                sum += acc_t'(a_w) * acc_t'(b_w);
            end
        end
        return sum;
    endfunction

    task automatic check_acc(input string what, input acc_t expected, input acc_t actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("[FAIL] %s %s: expected 0x%h, actual 0x%h", test_name, what, expected, actual);
        end
    endtask

    task automatic check_index(input string what, input logic [DIM_W-1:0] expected,
                               input logic [DIM_W-1:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("[FAIL] %s %s: expected %0d, actual %0d", test_name, what, expected, actual);
        end
    endtask

    task automatic expect_level(input string what, input logic expected, input logic actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("[FAIL] %s %s: expected %b, actual %b", test_name, what, expected, actual);
        end
    endtask

    task automatic load_word(input bank_e bank, input int index, input word_t data);
        @(negedge clk);
        load_en    = 1'b1;
        load_bank  = bank;
        load_index = INDEX_W'(index);
        load_data  = data;
        model_mem[int'(bank)][index] = data;
        @(negedge clk);
        load_en = 1'b0;
    endtask

    task automatic fill_banks(input int depth, input bit patterned);
        int    b;
        int    k;
        word_t data;
        for (b = 0; b < 4; b++) begin
            for (k = 0; k < depth; k++) begin
                data = patterned ? word_t'(32'hF000 | (b << 8) | k) : word_t'($urandom);
                load_word(bank_e'(b), k, data);
            end
        end
    endtask

    task automatic run_matrix(input int rows, input int cols,
                              input logic [BM_A_W-1:0] bm_a, input logic [BM_B_W-1:0] bm_b);
        int r;
        int c;
        for (r = 0; r < rows; r++) begin
            for (c = 0; c < cols; c++) begin
                exp_val.push_back(expected_dot(bm_a, bm_b, r, c));
                exp_row.push_back(DIM_W'(r));
                exp_col.push_back(DIM_W'(c));
            end
        end
        @(negedge clk);
        num_rows = DIM_W'(rows);
        num_cols = DIM_W'(cols);
        bitmap_a = bm_a;
        bitmap_b = bm_b;
        start    = 1'b1;
        @(negedge clk);
        start = 1'b0;
        expect_level("busy after start", 1'b1, busy);
        while (done !== 1'b1) begin
            @(negedge clk);
        end
        if (exp_val.size() != 0) begin
            error_count++;
            $display("%s: done arrived with %0d results still missing", test_name, exp_val.size());
        end
        @(negedge clk);
        expect_level("done pulse width", 1'b0, done);
        expect_level("busy after done", 1'b0, busy);
    endtask

    task automatic begin_test(input string name, input int pairs, input int loads);
        test_name     = name;
        wd_limit      = pairs * 20 + loads * 2 + 32;  // slack for start, done and idle checks
        wd_count      = 0;
        test_err_base = error_count;
        test_res_base = result_count;
    endtask

    task automatic end_test();
        test_count++;
        $display("test %-16s results %0d, errors %0d", test_name,
                 result_count - test_res_base, error_count - test_err_base);
    endtask

    // results are registered, so the falling edge sees them settled
    initial begin
        acc_t             want_val;
        logic [DIM_W-1:0] want_row;
        logic [DIM_W-1:0] want_col;
        forever begin
            @(negedge clk);
            if (rst === 1'b1 && result_valid === 1'b1) begin
                result_count++;
                if (exp_val.size() == 0) begin
                    error_count++;
                    $display("%s: unexpected result for row %0d col %0d", test_name,
                             result_row, result_col);
                end else begin
                    want_val = exp_val.pop_front();
                    want_row = exp_row.pop_front();
                    want_col = exp_col.pop_front();
                    check_index("result row", want_row, result_row);
                    check_index("result col", want_col, result_col);
                    check_acc("result value", want_val, result_value);
                end
            end
        end
    end

    initial begin
        while (wd_count <= wd_limit) begin
            @(posedge clk);
            wd_count++;
        end
        $display("timeout: %s did not finish within %0d cycles", test_name, wd_limit);
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin
        logic [BM_A_W-1:0] bm_a;
        logic [BM_B_W-1:0] bm_b;
        void'($urandom(32'ha3c849ee));
        rst        = 1'b0;
        load_en    = 1'b0;
        load_bank  = BANK_A0;
        load_index = '0;
        load_data  = '0;
        start      = 1'b0;
        num_rows   = '0;
        num_cols   = '0;
        bitmap_a   = '0;
        bitmap_b   = '0;
        repeat (8) @(negedge clk);
        rst = 1'b1;

        begin_test("full_bitmaps", 4, 32);
        fill_banks(MAX_DIM, 1'b1);  // large values push the sum into the carry bit
        run_matrix(2, 2, '1, '1);
        end_test();

        begin_test("random_sparse", 3 * 64, 32);
        fill_banks(MAX_DIM, 1'b0);
        repeat (3) begin
            bm_a = BM_A_W'($urandom);
            bm_b = BM_B_W'($urandom);
            run_matrix(MAX_ROWS, MAX_COLS, bm_a, bm_b);
        end
        end_test();

        begin_test("empty_masks", 12 + 25, 0);
        run_matrix(4, 3, '0, '1);
        run_matrix(5, 5, {MAX_ROWS{2'b01}}, {MAX_COLS{2'b10}});  // lanes never meet
        end_test();

        begin_test("load_during_run", 64, 32 + 24);
        fill_banks(MAX_DIM, 1'b0);
        bm_a = BM_A_W'($urandom) & {MAX_ROWS{2'b01}};  // bank A1 is never read
        bm_b = BM_B_W'($urandom);
        fork
            run_matrix(MAX_ROWS, MAX_COLS, bm_a, bm_b);
            begin
                while (busy !== 1'b1) begin
                    @(negedge clk);
                end
                repeat (24) begin
                    load_word(BANK_A1, $urandom_range(MAX_DIM - 1), word_t'($urandom));
                end
            end
        join
        end_test();

        begin_test("back_to_back", 15 + 12, 0);
        run_matrix(3, 5, BM_A_W'($urandom), BM_B_W'($urandom));
        repeat (3) begin
            @(negedge clk);
            expect_level("busy between runs", 1'b0, busy);
        end
        run_matrix(6, 2, BM_A_W'($urandom), BM_B_W'($urandom));
        end_test();

        $display("summary: %0d tests, %0d results, %0d checks, %0d errors",
                 test_count, result_count, check_count, error_count);
        if (error_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- compile.f
verilog/sparse_pkg.sv
verilog/sparse_ifs.sv
verilog/pair_walker.sv
verilog/operand_fetch.sv
verilog/value_store.sv
verilog/dot_accumulate.sv
verilog/sparse_dot_top.sv
dv/tb_clock_gen.sv
dv/tb_sparse_dot.sv

//--- run.sh
#!/bin/sh
# Build the sparse dot-product testbench with Verilator and run it.
# Exit status is 0 only when the simulation log holds the pass line.

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f compile.f --top-module tb_sparse_dot -o tb_sparse_dot > "$BUILD_LOG" 2>&1
status=$?
if [ $status -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/tb_sparse_dot > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^NO ERRORS$" "$SIM_LOG"; then
    exit 0
fi
exit 1
